/* logic/lkrt_pkg.sv */
// look-ahead route package
// port numbering and port vector types shared by the 2D mesh look-ahead route stage

package lkrt_pkg;

    // mesh router ports, local plus four directions
    localparam int NUM_PORTS = 5;

    // port vectors that leave out one position (input port or arrival port)
    localparam int NUM_LK_PORTS = NUM_PORTS - 1;

    // width of a binary port number
    localparam int PORT_BIN_W = $clog2(NUM_PORTS);

    // port positions inside a one-hot vector
    // EAST is x+1, WEST is x-1, NORTH is y-1, SOUTH is y+1
    typedef enum logic [PORT_BIN_W-1:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_idx_e;

    // one bit per router port
    typedef logic [NUM_PORTS-1:0] port_onehot_t;

    // one-hot port with one position removed
    typedef logic [NUM_LK_PORTS-1:0] lk_port_t;

    // binary port number
    typedef logic [PORT_BIN_W-1:0] port_bin_t;

endpackage

/* logic/route_input_reg.sv */
// input register of the look-ahead route stage
// holds destination and encoded output port for one cycle

`timescale 1ns/1ps

module route_input_reg
    import lkrt_pkg::*;
#(
    parameter int NX  = 4,
    parameter int NY  = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [XW-1:0] dest_x,
    input  logic [YW-1:0] dest_y,
    input  lk_port_t      destport,
    output logic [XW-1:0] dest_x_q,
    output logic [YW-1:0] dest_y_q,
    output lk_port_t      destport_q
);

    // new header every cycle, no enable needed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dest_x_q   <= '0;
            dest_y_q   <= '0;
            destport_q <= '0;   // no port selected after reset
        end else begin
            dest_x_q   <= dest_x;
            dest_y_q   <= dest_y;
            destport_q <= destport;
        end
    end

endmodule

/* logic/next_hop_predictor.sv */
// next hop predictor
// restores the full one-hot port, steps the address with edge wrap and mirrors the port
// to get the input port the packet will arrive on at the next router

`timescale 1ns/1ps

module next_hop_predictor
    import lkrt_pkg::*;
#(
    parameter int SW_LOC = 0,
    parameter int NX     = 4,
    parameter int NY     = 4,
    localparam int XW    = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW    = (NY > 1) ? $clog2(NY) : 1
) (
    input  lk_port_t      destport,
    input  logic [XW-1:0] current_x,
    input  logic [YW-1:0] current_y,
    output logic [XW-1:0] next_x,
    output logic [YW-1:0] next_y,
    output port_onehot_t  receive_port
);

    typedef logic [XW-1:0] x_coord_t;
    typedef logic [YW-1:0] y_coord_t;

    localparam x_coord_t LAST_X = x_coord_t'(NX - 1);
    localparam y_coord_t LAST_Y = y_coord_t'(NY - 1);

    port_onehot_t port_oh;

    // put back the input port position, it never carries a request
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_add_sw_loc
        if (i > SW_LOC) begin : g_above
            assign port_oh[i] = destport[i-1];
        end else if (i == SW_LOC) begin : g_own
            assign port_oh[i] = 1'b0;
        end else begin : g_below
            assign port_oh[i] = destport[i];
        end
    end

    // one step along the chosen direction
    always_comb begin
        next_x = current_x;
        next_y = current_y;
        if (port_oh[EAST]) begin
            next_x = (current_x == LAST_X) ? '0 : current_x + 1'b1;
        end else if (port_oh[NORTH]) begin
            next_y = (current_y == '0) ? LAST_Y : current_y - 1'b1;   // north is y-1
        end else if (port_oh[WEST]) begin
            next_x = (current_x == '0) ? LAST_X : current_x - 1'b1;
        end else if (port_oh[SOUTH]) begin
            next_y = (current_y == LAST_Y) ? '0 : current_y + 1'b1;
        end
    end

    // leaving east means entering the next router from its west side
    always_comb begin
        receive_port        = '0;
        receive_port[LOCAL] = port_oh[LOCAL];
        receive_port[WEST]  = port_oh[EAST];
        receive_port[EAST]  = port_oh[WEST];
        receive_port[NORTH] = port_oh[SOUTH];
        receive_port[SOUTH] = port_oh[NORTH];
    end

endmodule

/* logic/xy_route_calc.sv */
// XY dimension-order routing
// resolves x first, then y, local when both match

`timescale 1ns/1ps

module xy_route_calc
    import lkrt_pkg::*;
#(
    parameter int NX  = 4,
    parameter int NY  = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic [XW-1:0] cur_x,
    input  logic [YW-1:0] cur_y,
    input  logic [XW-1:0] dest_x,
    input  logic [YW-1:0] dest_y,
    output port_onehot_t  route_port
);

    logic go_east;
    logic go_west;
    logic go_south;
    logic go_north;

    // unsigned compares, mesh has no wrap links
    assign go_east  = (dest_x > cur_x);
    assign go_west  = (dest_x < cur_x);
    assign go_south = (dest_y > cur_y);   // y grows southwards
    assign go_north = (dest_y < cur_y);

    always_comb begin
        route_port = '0;
        if (go_east) begin
            route_port[EAST] = 1'b1;
        end else if (go_west) begin
            route_port[WEST] = 1'b1;
        end else if (go_south) begin
            // x done, turn into y
            route_port[SOUTH] = 1'b1;
        end else if (go_north) begin
            route_port[NORTH] = 1'b1;
        end else begin
            route_port[LOCAL] = 1'b1;   // arrived
        end
    end

endmodule

/* logic/receive_port_strip.sv */
// arrival port removal
// drops the next router's input position from its one-hot output decision

`timescale 1ns/1ps

module receive_port_strip
    import lkrt_pkg::*;
(
    input  port_onehot_t route_port,
    input  port_onehot_t receive_port,
    output lk_port_t     lkdestport
);

    localparam int LK_BIN_W = $clog2(NUM_LK_PORTS);

    port_bin_t           route_bin;
    port_bin_t           recv_bin;
    port_bin_t           out_bin;
    logic [LK_BIN_W-1:0] lk_bin;

    // highest set bit wins, all zero gives port 0
    function automatic port_bin_t onehot_to_bin(input port_onehot_t oh);
        port_bin_t idx;
        idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (oh[i]) begin
                idx = port_bin_t'(i);
            end
        end
        return idx;
    endfunction

    assign route_bin = onehot_to_bin(route_port);
    assign recv_bin  = onehot_to_bin(receive_port);

    // ports above the arrival position move down by one
    assign out_bin = (recv_bin > route_bin) ? route_bin : route_bin - 1'b1;

    assign lk_bin = out_bin[LK_BIN_W-1:0];   // four positions left

    assign lkdestport = lk_port_t'(1) << lk_bin;

endmodule

/* logic/lookahead_route_top.sv */
// look-ahead route stage of a 2D mesh router
// registers the header fields, then predicts the next hop and its XY output port

`timescale 1ns/1ps

module lookahead_route_top
    import lkrt_pkg::*;
#(
    parameter int NX     = 4,
    parameter int NY     = 4,
    parameter int SW_LOC = 0,
    localparam int XW    = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW    = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [XW-1:0] current_x,   // this router, not registered
    input  logic [YW-1:0] current_y,
    input  logic [XW-1:0] dest_x,
    input  logic [YW-1:0] dest_y,
    input  lk_port_t      destport,    // output port chosen at this router
    output lk_port_t      lkdestport   // output port for the next router
);

    typedef logic [XW-1:0] x_coord_t;
    typedef logic [YW-1:0] y_coord_t;

    x_coord_t     dest_x_q;
    y_coord_t     dest_y_q;
    lk_port_t     destport_q;
    x_coord_t     next_x;
    y_coord_t     next_y;
    port_onehot_t receive_port;
    port_onehot_t route_port;

    route_input_reg #(
        .NX (NX),
        .NY (NY)
    ) u_input_reg (
        .clk        (clk),
        .reset      (reset),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .destport   (destport),
        .dest_x_q   (dest_x_q),
        .dest_y_q   (dest_y_q),
        .destport_q (destport_q)
    );

    next_hop_predictor #(
        .SW_LOC (SW_LOC),
        .NX     (NX),
        .NY     (NY)
    ) u_next_hop (
        .destport     (destport_q),
        .current_x    (current_x),
        .current_y    (current_y),
        .next_x       (next_x),
        .next_y       (next_y),
        .receive_port (receive_port)
    );

    // routing decision as seen from the next router
    xy_route_calc #(
        .NX (NX),
        .NY (NY)
    ) u_xy_route (
        .cur_x      (next_x),
        .cur_y      (next_y),
        .dest_x     (dest_x_q),
        .dest_y     (dest_y_q),
        .route_port (route_port)
    );

    receive_port_strip u_strip (
        .route_port   (route_port),
        .receive_port (receive_port),
        .lkdestport   (lkdestport)
    );

endmodule

/* verification/lookahead_route_model.svh */
// reference model of the look-ahead route stage
// XY decision, next hop with edge wrap, arrival port and its removal

`ifndef LOOKAHEAD_ROUTE_MODEL_SVH
`define LOOKAHEAD_ROUTE_MODEL_SVH

// dimension-order decision, x before y
function automatic int xy_port(input int cx, input int cy, input int dx, input int dy);
    if (dx > cx) begin
        return EAST;
    end else if (dx < cx) begin
        return WEST;
    end else if (dy > cy) begin
        return SOUTH;   // y grows southwards
    end else if (dy < cy) begin
        return NORTH;
    end
    return LOCAL;
endfunction

// one step in x, wraps at the mesh edge
function automatic int step_x(input int cx, input int port);
    int nxt;
    nxt = cx;
    if (port == EAST) begin
        nxt = (cx + 1) % NX;
    end else if (port == WEST) begin
        nxt = (cx + NX - 1) % NX;
    end
    return nxt;
endfunction

function automatic int step_y(input int cy, input int port);
    int nxt;
    nxt = cy;
    if (port == SOUTH) begin
        nxt = (cy + 1) % NY;
    end else if (port == NORTH) begin
        nxt = (cy + NY - 1) % NY;   // north is y-1
    end
    return nxt;
endfunction

// leaving on one side means entering the next router on the opposite side
function automatic int mirror_port(input int port);
    case (port)
        EAST:    return WEST;
        WEST:    return EAST;
        NORTH:   return SOUTH;
        SOUTH:   return NORTH;
        default: return LOCAL;
    endcase
endfunction

// four-bit port vector with the switch position left out
function automatic lk_port_t encode_destport(input int port);
    int pos;
    pos = (port > SW_LOC) ? port - 1 : port;
    return lk_port_t'(1) << pos;
endfunction

function automatic lk_port_t expected_lkport(input int cx, input int cy,
                                             input int dx, input int dy);
    int out_port;
    int nxt_x;
    int nxt_y;
    int route;
    int arrive;
    int idx;
    out_port = xy_port(cx, cy, dx, dy);
    nxt_x    = step_x(cx, out_port);
    nxt_y    = step_y(cy, out_port);
    arrive   = mirror_port(out_port);
    route    = xy_port(nxt_x, nxt_y, dx, dy);
    idx      = (arrive > route) ? route : route - 1;   // ports above arrival shift down
    return lk_port_t'(1) << ((idx + NUM_LK_PORTS) % NUM_LK_PORTS);
endfunction

task automatic check_lkport(input string test_name, input lk_port_t expected,
                            input lk_port_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %b actual %b", test_name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "lkdestport mismatch in %s", test_name);
    end
endtask

`endif

/* verification/lookahead_route_tb.sv */
// testbench for the look-ahead route stage
// directed and random XY traffic on a 4x4 mesh, checked one cycle later

`timescale 1ns/1ps

module lookahead_route_tb
    import lkrt_pkg::*;
();

    localparam int NX             = 4;
    localparam int NY             = 4;
    localparam int SW_LOC         = 2;   // input port on the north side
    localparam int XW             = $clog2(NX);
    localparam int YW             = $clog2(NY);
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_DIRECTED   = 7;
    localparam int NUM_RANDOM     = 2000;
    // every vector takes one cycle, plus reset, flush and some slack
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 85;

    typedef logic [XW-1:0] x_coord_t;
    typedef logic [YW-1:0] y_coord_t;

    logic     clk;
    logic     reset;
    x_coord_t current_x;
    y_coord_t current_y;
    x_coord_t dest_x;
    y_coord_t dest_y;
    lk_port_t destport;
    lk_port_t lkdestport;

    integer   seed;
    int       cycle_count;
    bit       pending_valid;   // a vector waits in the input register
    lk_port_t pending_expected;
    string    pending_name;

    // path kinds of the random traffic at the next router
    int       n_straight;
    int       n_turn;
    int       n_arrival;
    int       n_recv_above;
    int       n_recv_below;

    `include "lookahead_route_model.svh"

    lookahead_route_top #(
        .NX     (NX),
        .NY     (NY),
        .SW_LOC (SW_LOC)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .current_x  (current_x),
        .current_y  (current_y),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .destport   (destport),
        .lkdestport (lkdestport)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic note_path(input int cx, input int cy, input int dx, input int dy);
        int out_port;
        int route;
        int arrive;
        out_port = xy_port(cx, cy, dx, dy);
        route    = xy_port(step_x(cx, out_port), step_y(cy, out_port), dx, dy);
        arrive   = mirror_port(out_port);
        if (route == out_port) begin
            n_straight++;
        end else if (route == LOCAL) begin
            n_arrival++;
        end else begin
            n_turn++;
        end
        if (arrive > route) begin
            n_recv_above++;
        end else begin
            n_recv_below++;
        end
    endtask

    // check the vector in the register, then drive the next one
    task automatic apply_vector(input int cx, input int cy, input int dx, input int dy,
                                input string name);
        @(posedge clk);
        #0.5;   // register settled, current still belongs to the held vector
        if (pending_valid) begin
            check_lkport(pending_name, pending_expected, lkdestport);
        end
        #0.5;
        current_x        = x_coord_t'(cx);
        current_y        = y_coord_t'(cy);
        dest_x           = x_coord_t'(dx);
        dest_y           = y_coord_t'(dy);
        destport         = encode_destport(xy_port(cx, cy, dx, dy));
        pending_expected = expected_lkport(cx, cy, dx, dy);
        pending_name     = name;
        pending_valid    = 1'b1;
    endtask

    task automatic flush_pipeline();
        @(posedge clk);
        #0.5;
        if (pending_valid) begin
            check_lkport(pending_name, pending_expected, lkdestport);
        end
        pending_valid = 1'b0;
    endtask

    // current differs from dest, and the first hop never leaves through SW_LOC
    task automatic draw_random(output int cx, output int cy, output int dx, output int dy);
        do begin
            cx = $unsigned($random(seed)) % NX;
            cy = $unsigned($random(seed)) % NY;
            dx = $unsigned($random(seed)) % NX;
            dy = $unsigned($random(seed)) % NY;
        end while ((cx == dx && cy == dy) || xy_port(cx, cy, dx, dy) == SW_LOC);
    endtask

    task automatic stop_on_coverage_gap(input string what);
        $display("ERROR: %s", what);
        $display("Testbench failed");
        $fatal(1, "random traffic missed a path kind");
    endtask

    task automatic confirm_path_coverage();
        if (n_straight == 0) begin
            stop_on_coverage_gap("no packet continued straight at the next router");
        end
        if (n_turn == 0) begin
            stop_on_coverage_gap("no packet turned at the next router");
        end
        if (n_arrival == 0) begin
            stop_on_coverage_gap("no packet reached its destination at the next router");
        end
        if (n_recv_above == 0 || n_recv_below == 0) begin
            stop_on_coverage_gap("arrival port was not seen on both sides of the route port");
        end
    endtask

    initial begin
        int cx;
        int cy;
        int dx;
        int dy;
        seed          = 32'h462f8003;
        pending_valid = 1'b0;
        pending_name  = "";
        n_straight    = 0;
        n_turn        = 0;
        n_arrival     = 0;
        n_recv_above  = 0;
        n_recv_below  = 0;
        reset         = 1'b1;
        current_x     = '0;
        current_y     = '0;
        dest_x        = '0;
        dest_y        = '0;
        destport      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        apply_vector(0, 1, 3, 1, "straight_east");   // arrives west, leaves east
        apply_vector(1, 0, 2, 3, "turn_south");
        apply_vector(0, 3, 1, 0, "turn_north");
        apply_vector(2, 2, 3, 2, "arrival_from_west");
        apply_vector(1, 1, 1, 2, "arrival_from_north");
        apply_vector(3, 0, 2, 2, "west_then_south");  // arrival below route
        apply_vector(1, 0, 1, 3, "straight_south");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_random(cx, cy, dx, dy);
            note_path(cx, cy, dx, dy);
            apply_vector(cx, cy, dx, dy, $sformatf("random_%0d", i));
        end
        flush_pipeline();

        confirm_path_coverage();
        $display("paths: straight %0d turn %0d arrival %0d", n_straight, n_turn, n_arrival);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+verification
logic/lkrt_pkg.sv
logic/route_input_reg.sv
logic/next_hop_predictor.sv
logic/xy_route_calc.sv
logic/receive_port_strip.sv
logic/lookahead_route_top.sv
verification/lookahead_route_tb.sv
